// File: logic/perf_pkg.sv
// ------------------------------------------------------------------------
// Performance counter package
// Widths, register addresses, event codes, sampling states and the
// decoded event strobes shared by the counter block
// ------------------------------------------------------------------------
`default_nettype none

package perf_pkg;

  localparam int unsigned NUM_COUNTERS = 6;
  localparam int unsigned CNT_W        = 64;
  localparam int unsigned ADDR_W       = 12;
  localparam int unsigned EVT_SEL_W    = 5;

  // Sample FIFO geometry
  localparam int unsigned FIFO_DEPTH   = 16;
  localparam int unsigned FIFO_PTR_W   = 4;
  localparam int unsigned FIFO_CNT_W   = 5;
  localparam int unsigned FLUSH_LEVEL  = 12;  // Three quarters full

  typedef logic [CNT_W-1:0]        cnt_t;
  typedef logic [ADDR_W-1:0]       addr_t;
  typedef logic [CNT_W-1:0]        data_t;
  typedef logic [2:0]              idx_t;
  typedef logic [NUM_COUNTERS-1:0] cfg_mask_t;

  // ------------------------------------------------------------------------
  // Register map, base address of each group of six
  // ------------------------------------------------------------------------
  localparam addr_t CSR_MHPM_COUNTER_3   = 12'hB03;
  localparam addr_t CSR_HPM_COUNTER_3    = 12'hC03;  // User read-only alias
  localparam addr_t CSR_MHPM_EVENT_3     = 12'h323;
  localparam addr_t CSR_MHPM_THRESHOLD_3 = 12'h7C3;
  localparam addr_t CSR_MHPM_EBS_CFG     = 12'h7D0;

  typedef enum logic [EVT_SEL_W-1:0] {
    EVT_NONE        = 5'd0,
    EVT_ICACHE_MISS = 5'd1,
    EVT_DCACHE_MISS = 5'd2,
    EVT_ITLB_MISS   = 5'd3,
    EVT_DTLB_MISS   = 5'd4,
    EVT_LOAD        = 5'd5,
    EVT_STORE       = 5'd6,
    EVT_EXCEPTION   = 5'd7,
    EVT_ERET        = 5'd8,
    EVT_BRANCH      = 5'd9,
    EVT_MISPREDICT  = 5'd10
  } event_sel_e;

  typedef enum logic [1:0] {
    SAMPLE_IDLE = 2'd0,
    SAMPLE_SCAN = 2'd1
  } sample_state_e;

  // Pre-decoded single-cycle strobes from the core
  typedef struct packed {
    logic icache_miss;
    logic dcache_miss;
    logic itlb_miss;
    logic dtlb_miss;
    logic load;
    logic store;
    logic exception;
    logic eret;
    logic branch;
    logic mispredict;
  } perf_events_t;

endpackage

`default_nettype wire

// File: logic/perf_event_select.sv
// ------------------------------------------------------------------------
// Event select
// Routes one event strobe to each counter according to its event code
// ------------------------------------------------------------------------
`default_nettype none

module perf_event_select (
  input  perf_pkg::perf_events_t                              events_i,
  input  perf_pkg::event_sel_e [perf_pkg::NUM_COUNTERS-1:0]   evt_sel_i,
  output perf_pkg::cfg_mask_t                                 cnt_event_o
);

  always_comb begin
    cnt_event_o = '0;
    for (int unsigned i = 0; i < perf_pkg::NUM_COUNTERS; i++) begin
      case (evt_sel_i[i])
        perf_pkg::EVT_ICACHE_MISS: cnt_event_o[i] = events_i.icache_miss;
        perf_pkg::EVT_DCACHE_MISS: cnt_event_o[i] = events_i.dcache_miss;
        perf_pkg::EVT_ITLB_MISS:   cnt_event_o[i] = events_i.itlb_miss;
        perf_pkg::EVT_DTLB_MISS:   cnt_event_o[i] = events_i.dtlb_miss;
        perf_pkg::EVT_LOAD:        cnt_event_o[i] = events_i.load;
        perf_pkg::EVT_STORE:       cnt_event_o[i] = events_i.store;
        perf_pkg::EVT_EXCEPTION:   cnt_event_o[i] = events_i.exception;
        perf_pkg::EVT_ERET:        cnt_event_o[i] = events_i.eret;
        perf_pkg::EVT_BRANCH:      cnt_event_o[i] = events_i.branch;
        perf_pkg::EVT_MISPREDICT:  cnt_event_o[i] = events_i.mispredict;
        default:                   cnt_event_o[i] = 1'b0;  // None or unknown code
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/perf_counter_bank.sv
// ------------------------------------------------------------------------
// Counter bank
// Six 64-bit event counters with inhibit and debug gating, loadable
// through the register port
// ------------------------------------------------------------------------
`default_nettype none

module perf_counter_bank (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  perf_pkg::cfg_mask_t                           cnt_event_i,
  input  perf_pkg::cfg_mask_t                           inhibit_i,  // Bit 0 is counter 3
  input  logic                                          debug_mode_i,
  input  logic                                          wr_en_i,
  input  perf_pkg::idx_t                                wr_idx_i,
  input  perf_pkg::cnt_t                                wr_data_i,
  input  logic                                          any_write_i,
  output perf_pkg::cnt_t [perf_pkg::NUM_COUNTERS-1:0]   count_o
);

  perf_pkg::cnt_t [perf_pkg::NUM_COUNTERS-1:0] count_q;
  perf_pkg::cfg_mask_t                         count_en;
  logic                                        global_en;

  // No counting in debug mode or while the register port writes
  assign global_en = !debug_mode_i && !any_write_i;
  assign count_en  = cnt_event_i & ~inhibit_i & {perf_pkg::NUM_COUNTERS{global_en}};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else begin
      for (int unsigned i = 0; i < perf_pkg::NUM_COUNTERS; i++) begin
        if (wr_en_i && (wr_idx_i == perf_pkg::idx_t'(i))) begin
          count_q[i] <= wr_data_i;  // Preload wins over counting
        end else if (count_en[i]) begin
          count_q[i] <= count_q[i] + perf_pkg::cnt_t'(1);
        end
      end
    end
  end

  assign count_o = count_q;

  // The CSR decoder only hands over indices of existing counters
  a_wr_idx_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_en_i |-> (wr_idx_i < perf_pkg::NUM_COUNTERS));

endmodule

`default_nettype wire

// File: logic/perf_csr_regs.sv
// ------------------------------------------------------------------------
// Counter register file
// Address decode for counters, event selectors, thresholds and the
// sample configuration, with a same-cycle read path
// ------------------------------------------------------------------------
`default_nettype none

module perf_csr_regs (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  perf_pkg::addr_t                                   addr_i,
  input  logic                                              we_i,
  input  perf_pkg::data_t                                   data_i,
  output perf_pkg::data_t                                   data_o,
  input  perf_pkg::cnt_t [perf_pkg::NUM_COUNTERS-1:0]       count_i,
  output logic                                              cnt_we_o,
  output perf_pkg::idx_t                                    cnt_idx_o,
  output perf_pkg::cnt_t                                    cnt_data_o,
  output logic                                              any_write_o,
  output perf_pkg::event_sel_e [perf_pkg::NUM_COUNTERS-1:0] evt_sel_o,
  output perf_pkg::cnt_t [perf_pkg::NUM_COUNTERS-1:0]       threshold_o,
  output perf_pkg::cfg_mask_t                               sample_cfg_o
);

  localparam perf_pkg::addr_t GroupSize = perf_pkg::addr_t'(perf_pkg::NUM_COUNTERS);

  perf_pkg::event_sel_e [perf_pkg::NUM_COUNTERS-1:0] evt_sel_q;
  perf_pkg::cnt_t [perf_pkg::NUM_COUNTERS-1:0]       threshold_q;
  perf_pkg::cfg_mask_t                               cfg_q;

  perf_pkg::addr_t cnt_off, hpm_off, sel_off, thr_off;
  logic            cnt_hit, hpm_hit, sel_hit, thr_hit, cfg_hit;
  logic            sel_we, thr_we, cfg_we;

  // ------------------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------------------
  assign cnt_off = addr_i - perf_pkg::CSR_MHPM_COUNTER_3;
  assign hpm_off = addr_i - perf_pkg::CSR_HPM_COUNTER_3;
  assign sel_off = addr_i - perf_pkg::CSR_MHPM_EVENT_3;
  assign thr_off = addr_i - perf_pkg::CSR_MHPM_THRESHOLD_3;

  assign cnt_hit = cnt_off < GroupSize;
  assign hpm_hit = hpm_off < GroupSize;
  assign sel_hit = sel_off < GroupSize;
  assign thr_hit = thr_off < GroupSize;
  assign cfg_hit = addr_i == perf_pkg::CSR_MHPM_EBS_CFG;

  // User aliases are read only so a write there is dropped
  assign cnt_we_o    = we_i && cnt_hit;
  assign sel_we      = we_i && sel_hit;
  assign thr_we      = we_i && thr_hit;
  assign cfg_we      = we_i && cfg_hit;
  assign cnt_idx_o   = perf_pkg::idx_t'(cnt_off);
  assign cnt_data_o  = data_i;
  assign any_write_o = we_i;

  // Read mux
  always_comb begin
    data_o = '0;
    if (cnt_hit) begin
      data_o = count_i[cnt_off[2:0]];
    end else if (hpm_hit) begin
      data_o = count_i[hpm_off[2:0]];
    end else if (sel_hit) begin
      data_o = perf_pkg::data_t'(evt_sel_q[sel_off[2:0]]);
    end else if (thr_hit) begin
      data_o = threshold_q[thr_off[2:0]];
    end else if (cfg_hit) begin
      data_o = perf_pkg::data_t'(cfg_q);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_sel_q   <= '{default: perf_pkg::EVT_NONE};
      threshold_q <= '0;
      cfg_q       <= '0;
    end else begin
      if (sel_we) begin
        evt_sel_q[sel_off[2:0]] <= perf_pkg::event_sel_e'(data_i[perf_pkg::EVT_SEL_W-1:0]);
      end
      if (thr_we) begin
        threshold_q[thr_off[2:0]] <= data_i;
      end
      if (cfg_we) begin
        cfg_q <= data_i[perf_pkg::NUM_COUNTERS-1:0];
      end
    end
  end

  assign evt_sel_o    = evt_sel_q;
  assign threshold_o  = threshold_q;
  assign sample_cfg_o = cfg_q;

  // Register groups never overlap in the map
  a_one_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({cnt_we_o, sel_we, thr_we, cfg_we}));

endmodule

`default_nettype wire

// File: logic/perf_sample_fsm.sv
// ------------------------------------------------------------------------
// Event-based sampling FSM
// Detects threshold crossings, snapshots all counters and walks the
// counter indices to push the configured samples
// ------------------------------------------------------------------------
`default_nettype none

module perf_sample_fsm (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  perf_pkg::cnt_t [perf_pkg::NUM_COUNTERS-1:0]   count_i,
  input  perf_pkg::cnt_t [perf_pkg::NUM_COUNTERS-1:0]   threshold_i,
  input  perf_pkg::cfg_mask_t                           sample_cfg_i,
  input  logic                                          fifo_full_i,
  output logic                                          push_o,
  output perf_pkg::cnt_t                                push_data_o
);

  localparam perf_pkg::idx_t LastIdx = perf_pkg::idx_t'(perf_pkg::NUM_COUNTERS - 1);

  perf_pkg::sample_state_e                     state_q;
  perf_pkg::idx_t                              idx_q;
  perf_pkg::cnt_t [perf_pkg::NUM_COUNTERS-1:0] offset_q;
  perf_pkg::cnt_t [perf_pkg::NUM_COUNTERS-1:0] snap_q;
  perf_pkg::cfg_mask_t                         hit;
  logic                                        trigger;

  // A zero threshold disables sampling for that counter
  always_comb begin
    for (int unsigned i = 0; i < perf_pkg::NUM_COUNTERS; i++) begin
      hit[i] = (threshold_i[i] != '0) && (count_i[i] >= threshold_i[i] + offset_q[i]);
    end
  end

  assign trigger = (state_q == perf_pkg::SAMPLE_IDLE) && (|hit);

  // One index per scan cycle and a full FIFO drops the entry
  assign push_o      = (state_q == perf_pkg::SAMPLE_SCAN) && sample_cfg_i[idx_q] && !fifo_full_i;
  assign push_data_o = snap_q[idx_q];

  // ------------------------------------------------------------------------
  // State, scan index and offsets
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= perf_pkg::SAMPLE_IDLE;
      idx_q    <= '0;
      offset_q <= '0;
    end else begin
      case (state_q)
        perf_pkg::SAMPLE_IDLE: begin
          if (trigger) begin
            state_q <= perf_pkg::SAMPLE_SCAN;
            idx_q   <= '0;
            for (int unsigned i = 0; i < perf_pkg::NUM_COUNTERS; i++) begin
              if (hit[i]) begin
                offset_q[i] <= count_i[i];  // Next trigger one threshold later
              end
            end
          end
        end
        perf_pkg::SAMPLE_SCAN: begin
          idx_q <= idx_q + perf_pkg::idx_t'(1);
          if (idx_q == LastIdx) begin
            state_q <= perf_pkg::SAMPLE_IDLE;
          end
        end
        default: state_q <= perf_pkg::SAMPLE_IDLE;
      endcase
    end
  end

  // Snapshot of every counter at the trigger edge
  always_ff @(posedge clk_i) begin
    if (trigger) begin
      snap_q <= count_i;
    end
  end

  // Pushes only come from the walk over existing counter indices
  a_push_in_scan: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_o |-> (state_q == perf_pkg::SAMPLE_SCAN) && (idx_q <= LastIdx));

endmodule

`default_nettype wire

// File: logic/perf_sample_fifo.sv
// ------------------------------------------------------------------------
// Sample FIFO
// Circular buffer for counter samples with a flush request near full
// ------------------------------------------------------------------------
`default_nettype none

module perf_sample_fifo (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           push_i,
  input  perf_pkg::cnt_t push_data_i,
  input  logic           pop_i,
  output logic           full_o,
  output logic           sample_valid_o,
  output perf_pkg::cnt_t sample_data_o,
  output logic           flush_o
);

  localparam int unsigned CntW = perf_pkg::FIFO_CNT_W;

  perf_pkg::cnt_t                  mem_q [perf_pkg::FIFO_DEPTH];
  logic [perf_pkg::FIFO_PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0]                 cnt_q;
  logic                            do_push, do_pop;

  assign full_o         = cnt_q == CntW'(perf_pkg::FIFO_DEPTH);
  assign sample_valid_o = cnt_q != '0;
  assign flush_o        = cnt_q >= CntW'(perf_pkg::FLUSH_LEVEL);
  assign sample_data_o  = mem_q[rd_ptr_q];

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && sample_valid_o;

  // Pointers wrap naturally at the power-of-two depth
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + perf_pkg::FIFO_PTR_W'(do_push);
      rd_ptr_q <= rd_ptr_q + perf_pkg::FIFO_PTR_W'(do_pop);
      cnt_q    <= cnt_q + CntW'(do_push) - CntW'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  a_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= CntW'(perf_pkg::FIFO_DEPTH));

  // The sampling FSM holds back while the buffer is full
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);

endmodule

`default_nettype wire

// File: logic/perf_counters_top.sv
// ------------------------------------------------------------------------
// Performance counters top level
// Event selection, counter bank, register port and event-based sampling
// ------------------------------------------------------------------------
`default_nettype none

module perf_counters_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   debug_mode_i,
  input  perf_pkg::cfg_mask_t    inhibit_i,
  input  perf_pkg::addr_t        addr_i,
  input  logic                   we_i,
  input  perf_pkg::data_t        data_i,
  output perf_pkg::data_t        data_o,
  input  perf_pkg::perf_events_t events_i,
  input  logic                   sample_pop_i,
  output logic                   sample_valid_o,
  output perf_pkg::cnt_t         sample_data_o,
  output logic                   flush_o
);

  perf_pkg::cfg_mask_t                               cnt_event;
  perf_pkg::cnt_t [perf_pkg::NUM_COUNTERS-1:0]       count;
  perf_pkg::event_sel_e [perf_pkg::NUM_COUNTERS-1:0] evt_sel;
  perf_pkg::cnt_t [perf_pkg::NUM_COUNTERS-1:0]       threshold;
  perf_pkg::cfg_mask_t                               sample_cfg;
  logic                                              cnt_we, any_write;
  perf_pkg::idx_t                                    cnt_idx;
  perf_pkg::cnt_t                                    cnt_data;
  logic                                              push, fifo_full;
  perf_pkg::cnt_t                                    push_data;

  perf_event_select u_event_select (
    .events_i    (events_i),
    .evt_sel_i   (evt_sel),
    .cnt_event_o (cnt_event)
  );

  perf_counter_bank u_counter_bank (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cnt_event_i  (cnt_event),
    .inhibit_i    (inhibit_i),
    .debug_mode_i (debug_mode_i),
    .wr_en_i      (cnt_we),
    .wr_idx_i     (cnt_idx),
    .wr_data_i    (cnt_data),
    .any_write_i  (any_write),
    .count_o      (count)
  );

  perf_csr_regs u_csr_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .addr_i       (addr_i),
    .we_i         (we_i),
    .data_i       (data_i),
    .data_o       (data_o),
    .count_i      (count),
    .cnt_we_o     (cnt_we),
    .cnt_idx_o    (cnt_idx),
    .cnt_data_o   (cnt_data),
    .any_write_o  (any_write),
    .evt_sel_o    (evt_sel),
    .threshold_o  (threshold),
    .sample_cfg_o (sample_cfg)
  );

  perf_sample_fsm u_sample_fsm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .count_i      (count),
    .threshold_i  (threshold),
    .sample_cfg_i (sample_cfg),
    .fifo_full_i  (fifo_full),
    .push_o       (push),
    .push_data_o  (push_data)
  );

  perf_sample_fifo u_sample_fifo (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (push),
    .push_data_i    (push_data),
    .pop_i          (sample_pop_i),
    .full_o         (fifo_full),
    .sample_valid_o (sample_valid_o),
    .sample_data_o  (sample_data_o),
    .flush_o        (flush_o)
  );

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
// ------------------------------------------------------------------------
// Testbench clock and reset
// 10 ns clock, active-low reset held for five cycles
// ------------------------------------------------------------------------
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned RESET_CYCLES = 5;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);  // Release away from the active edge
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: sim/tb_perf_counters.sv
// ------------------------------------------------------------------------
// Performance counter testbench
// Random event counting against a reference model, register readback,
// event-based sampling and FIFO back-pressure
// ------------------------------------------------------------------------
`default_nettype none

module tb_perf_counters;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned N           = perf_pkg::NUM_COUNTERS;
  localparam int unsigned RAND_CYCLES = 300;
  localparam int unsigned STIM_CYCLES = RAND_CYCLES + 260;  // Random plus directed phases
  // Distinct codes where the last one is undefined and never counts
  localparam logic [4:0]  SEL_CODES [N] = '{5'd1, 5'd5, 5'd6, 5'd9, 5'd10, 5'd17};

  logic                   clk, rst_n, debug_mode, we, pop;
  logic                   sample_valid, flush;
  perf_pkg::cfg_mask_t    inhibit;
  perf_pkg::addr_t        addr;
  perf_pkg::data_t        wdata, rdata, exp_data;
  perf_pkg::perf_events_t events;
  perf_pkg::cnt_t         sample_data, exp_sample;
  logic                   chk_rd, chk_pop, chk_level, exp_valid, exp_flush;
  perf_pkg::cnt_t         ref_cnt [N];
  logic [4:0]             ref_sel [N];
  perf_pkg::cnt_t         exp_q [$];  // Samples the FIFO should hold
  int                     seed = 32'hfe5a_1aff;

  tb_clock_gen u_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  perf_counters_top u_perf_counters_top (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .debug_mode_i   (debug_mode),
    .inhibit_i      (inhibit),
    .addr_i         (addr),
    .we_i           (we),
    .data_i         (wdata),
    .data_o         (rdata),
    .events_i       (events),
    .sample_pop_i   (pop),
    .sample_valid_o (sample_valid),
    .sample_data_o  (sample_data),
    .flush_o        (flush)
  );

  function automatic perf_pkg::addr_t addr_of(perf_pkg::addr_t base, int i);
    return base + perf_pkg::addr_t'(i);
  endfunction

  // Code c picks bit 10-c of the strobe vector
  function automatic logic event_hit(perf_pkg::perf_events_t ev, logic [4:0] code);
    logic [9:0] bits;
    bits = ev;
    if (code == 5'd0 || code > 5'd10) begin
      return 1'b0;
    end
    return bits[4'(10 - int'(code))];
  endfunction

  // ------------------------------------------------------------------------
  // Reference model of the counters and the event selectors
  // ------------------------------------------------------------------------
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < N; i++) begin
        ref_cnt[i] <= '0;
        ref_sel[i] <= '0;
      end
    end else begin
      for (int i = 0; i < N; i++) begin
        if (we && addr == addr_of(12'hB03, i)) begin
          ref_cnt[i] <= wdata;
        end else if (!we && !debug_mode && !inhibit[i] && event_hit(events, ref_sel[i])) begin
          ref_cnt[i] <= ref_cnt[i] + 64'd1;
        end
        if (we && addr == addr_of(12'h323, i)) begin
          ref_sel[i] <= wdata[4:0];
        end
      end
    end
  end

  task automatic stop_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] act);
    $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
    stop_run();
  endtask

  a_read: assert property (@(posedge clk) disable iff (!rst_n) chk_rd |-> rdata == exp_data)
    else value_error("data_o", $sampled(exp_data), $sampled(rdata));
  a_pop_data: assert property (@(posedge clk) disable iff (!rst_n)
    chk_pop |-> sample_data == exp_sample)
    else value_error("sample_data_o", $sampled(exp_sample), $sampled(sample_data));
  a_valid: assert property (@(posedge clk) disable iff (!rst_n)
    chk_level |-> sample_valid == exp_valid)
    else value_error("sample_valid_o", 64'($sampled(exp_valid)), 64'($sampled(sample_valid)));
  a_flush: assert property (@(posedge clk) disable iff (!rst_n) chk_level |-> flush == exp_flush)
    else value_error("flush_o", 64'($sampled(exp_flush)), 64'($sampled(flush)));

  // ------------------------------------------------------------------------
  // Stimulus tasks that each drive a single cycle from the falling edge
  // ------------------------------------------------------------------------
  task automatic clear_controls();
    we         = 1'b0;
    addr       = '0;
    wdata      = '0;
    events     = '0;
    debug_mode = 1'b0;
    inhibit    = '0;
    pop        = 1'b0;
    chk_rd     = 1'b0;
    chk_pop    = 1'b0;
    chk_level  = 1'b0;
  endtask

  task automatic reg_write(input perf_pkg::addr_t a, input perf_pkg::data_t d);
    @(negedge clk);
    clear_controls();
    we    = 1'b1;
    addr  = a;
    wdata = d;
  endtask

  task automatic reg_check(input perf_pkg::addr_t a, input perf_pkg::data_t d);
    @(negedge clk);
    clear_controls();
    addr     = a;
    exp_data = d;
    chk_rd   = 1'b1;
  endtask

  // Expected count taken after the edge once the model has settled
  task automatic counter_check(input int i, input perf_pkg::addr_t base);
    @(negedge clk);
    clear_controls();
    addr     = addr_of(base, i);
    exp_data = ref_cnt[i];
    chk_rd   = 1'b1;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      clear_controls();
    end
  endtask

  task automatic level_check(input logic valid, input logic full);
    @(negedge clk);
    clear_controls();
    exp_valid = valid;
    exp_flush = full;
    chk_level = 1'b1;
  endtask

  task automatic load_events(input int n);
    repeat (n) begin
      @(negedge clk);
      clear_controls();
      events.load = 1'b1;  // Selected by counter 4 only
    end
  endtask

  // Trigger, scan and push fit in the wait; a full FIFO loses the rest
  task automatic expect_samples(input perf_pkg::cfg_mask_t cfg);
    idle(N + 3);
    for (int k = 0; k < N; k++) begin
      if (cfg[k] && exp_q.size() < perf_pkg::FIFO_DEPTH) begin
        exp_q.push_back(ref_cnt[k]);
      end
    end
  endtask

  // Flush level follows the fill count before each pop
  task automatic drain_fifo();
    while (exp_q.size() > 0) begin
      @(negedge clk);
      clear_controls();
      pop        = 1'b1;
      exp_valid  = 1'b1;
      exp_flush  = exp_q.size() >= perf_pkg::FLUSH_LEVEL;
      exp_sample = exp_q.pop_front();
      chk_pop    = 1'b1;
      chk_level  = 1'b1;
    end
    level_check(1'b0, 1'b0);
  endtask

  initial begin
    logic [31:0] rnd;
    clear_controls();
    @(posedge rst_n);
    for (int i = 0; i < N; i++)
      reg_write(addr_of(12'h323, i), perf_pkg::data_t'(SEL_CODES[i]));

    // Random strobes with debug, inhibit and write cycles mixed in
    repeat (RAND_CYCLES) begin
      @(negedge clk);
      clear_controls();
      rnd        = $random(seed);
      events     = perf_pkg::perf_events_t'(rnd[9:0]);
      debug_mode = rnd[12:10] == 3'd0;
      inhibit    = (rnd[14:13] == 2'd0) ? rnd[20:15] : '0;
      we         = rnd[23:21] == 3'd0;  // Unmapped address so data is ignored
      wdata      = {rnd, rnd};
    end
    for (int i = 0; i < N; i++) begin
      counter_check(i, 12'hB03);
      counter_check(i, 12'hC03);
    end

    // ------------------------------------------------------------------------
    // Register readback
    // ------------------------------------------------------------------------
    for (int i = 0; i < N; i++)
      reg_check(addr_of(12'h323, i), perf_pkg::data_t'(SEL_CODES[i]));
    for (int i = 0; i < N; i++)
      reg_write(addr_of(12'h7C3, i), {16'hffff, 48'(i)});  // Far above any count
    for (int i = 0; i < N; i++)
      reg_check(addr_of(12'h7C3, i), {16'hffff, 48'(i)});
    for (int i = 0; i < N; i++)
      reg_write(addr_of(12'h7C3, i), '0);
    reg_write(12'h7D0, 64'h27);
    reg_check(12'h7D0, 64'h27);
    reg_write(12'hC04, 64'hdead_beef);  // User alias is read only
    counter_check(1, 12'hC03);
    reg_check(12'h000, '0);
    reg_check(12'hB09, '0);
    reg_check(12'hC02, '0);
    reg_check(12'h7D1, '0);

    // Preload then count on top of it
    reg_write(12'hB04, 64'h100);
    reg_write(12'hB03, 64'h0123_4567_89ab_cdef);
    load_events(3);
    counter_check(1, 12'hB03);
    counter_check(0, 12'hB03);

    // ------------------------------------------------------------------------
    // Sampling on counter 4 with threshold 4
    // ------------------------------------------------------------------------
    reg_write(12'h7C4, 64'd4);  // Count already past the threshold
    expect_samples(6'h27);
    level_check(1'b1, 1'b0);
    drain_fifo();
    load_events(3);
    idle(N + 3);
    level_check(1'b0, 1'b0);  // Still one short of offset plus threshold
    load_events(1);
    expect_samples(6'h27);
    level_check(1'b1, 1'b0);
    drain_fifo();

    // Back-pressure with three samples per trigger until the FIFO overflows
    reg_write(12'h7D0, 64'h16);
    repeat (6) begin
      load_events(4);
      expect_samples(6'h16);
      level_check(1'b1, exp_q.size() >= perf_pkg::FLUSH_LEVEL);
    end
    drain_fifo();

    idle(2);
    $display("TEST RESULT: PASS");
    $finish;
  end

  // Watchdog at 1.5 times the stimulus length
  initial begin
    #(STIM_CYCLES * 10 * 3 / 2);
    $display("Watchdog expired before the stimulus completed");
    stop_run();
  end

endmodule

`default_nettype wire

// File: Bender.yml
package:
  name: perf_counters

sources:
  - logic/perf_pkg.sv
  - logic/perf_event_select.sv
  - logic/perf_counter_bank.sv
  - logic/perf_csr_regs.sv
  - logic/perf_sample_fsm.sv
  - logic/perf_sample_fifo.sv
  - logic/perf_counters_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_perf_counters.sv

// File: sim.f
logic/perf_pkg.sv
logic/perf_event_select.sv
logic/perf_counter_bank.sv
logic/perf_csr_regs.sv
logic/perf_sample_fsm.sv
logic/perf_sample_fifo.sv
logic/perf_counters_top.sv
sim/tb_clock_gen.sv
sim/tb_perf_counters.sv
